// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mem_subsys_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert -sv
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mem_subsys_checker.sv ====
// port-level handshake rules of mem_subsys_top; assumes the LSU has one transaction in flight
module mem_subsys_checker import bus_pkg::*; (
	input logic clock,
	input logic reset,
	input logic ifu_arready_o,
	input logic [DATA_W-1:0] ifu_rdata_o,
	input logic [1:0] ifu_rresp_o,
	input logic ifu_rlast_o,
	input logic ifu_rvalid_o,
	input logic ifu_rready_i,
	input logic lsu_arvalid_i,
	input logic lsu_arready_o,
	input logic [DATA_W-1:0] lsu_rdata_o,
	input logic [1:0] lsu_rresp_o,
	input logic lsu_rvalid_o,
	input logic lsu_rready_i,
	input logic lsu_awvalid_i,
	input logic lsu_awready_o,
	input logic lsu_wready_o,
	input logic [1:0] lsu_bresp_o,
	input logic lsu_bvalid_o,
	input logic lsu_bready_i
);

	timeunit 1ns;
	timeprecision 100ps;

	int quiet_err = 0;
	int ifu_hold_err = 0;
	int lsu_hold_err = 0;
	int b_hold_err = 0;
	int overlap_err = 0;
	int blocked_err = 0;
	int assert_errors;
	logic lsu_busy; // address taken, response pending

	assign assert_errors = quiet_err + ifu_hold_err + lsu_hold_err + b_hold_err
		+ overlap_err + blocked_err;

	always @(posedge clock) begin
		if (reset) begin
			lsu_busy <= 1'b0;
		end else if ((lsu_arvalid_i & lsu_arready_o) | (lsu_awvalid_i & lsu_awready_o)) begin
			lsu_busy <= 1'b1;
		end else if ((lsu_rvalid_o & lsu_rready_i) | (lsu_bvalid_o & lsu_bready_i)) begin
			lsu_busy <= 1'b0;
		end
	end

	quiet_after_reset: assert property (@(posedge clock) reset |=> !(ifu_arready_o | ifu_rvalid_o
			| lsu_arready_o | lsu_rvalid_o | lsu_awready_o | lsu_wready_o | lsu_bvalid_o))
		else begin
			quiet_err++;
			$error("valid or ready high right after reset");
		end

	ifu_r_hold: assert property (@(posedge clock) disable iff (reset)
			ifu_rvalid_o && !ifu_rready_i |=> ifu_rvalid_o
			&& $stable({ifu_rdata_o, ifu_rresp_o, ifu_rlast_o}))
		else begin
			ifu_hold_err++;
			$error("ifu read beat dropped or changed while stalled");
		end

	lsu_r_hold: assert property (@(posedge clock) disable iff (reset)
			lsu_rvalid_o && !lsu_rready_i |=> lsu_rvalid_o && $stable({lsu_rdata_o, lsu_rresp_o}))
		else begin
			lsu_hold_err++;
			$error("lsu read beat dropped or changed while stalled");
		end

	lsu_b_hold: assert property (@(posedge clock) disable iff (reset)
			lsu_bvalid_o && !lsu_bready_i |=> lsu_bvalid_o && $stable(lsu_bresp_o))
		else begin
			b_hold_err++;
			$error("lsu write response dropped or changed while stalled");
		end

	one_rvalid: assert property (@(posedge clock) disable iff (reset)
			!(ifu_rvalid_o && lsu_rvalid_o))
		else begin
			overlap_err++;
			$error("both masters see rvalid in the same cycle");
		end

	// the ifu stays shut out for the whole lsu transaction
	ifu_blocked: assert property (@(posedge clock) disable iff (reset)
			(lsu_busy | lsu_arready_o | lsu_awready_o) |-> !(ifu_arready_o | ifu_rvalid_o))
		else begin
			blocked_err++;
			$error("ifu handshake during an lsu transaction");
		end

endmodule

bind mem_subsys_top mem_subsys_checker mem_subsys_checker_inst (.*);

// ==== bench/mem_subsys_tb.sv ====
// SRAM starts unknown, so each word is written before it is read; SRAM traffic stays at 0x8000_xxxx
module mem_subsys_tb import bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TRANS = 27;
	localparam int WATCHDOG_CYCLES = N_TRANS * 40 + 200;

	logic clock = 1'b0;
	logic reset;
	logic [ADDR_W-1:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i;
	logic [LEN_W-1:0] ifu_arlen_i;
	logic [1:0] ifu_arburst_i;
	logic ifu_arvalid_i, ifu_rready_i, lsu_arvalid_i, lsu_rready_i;
	logic lsu_awvalid_i, lsu_wvalid_i, lsu_bready_i;
	logic [DATA_W-1:0] lsu_wdata_i;
	logic [STRB_W-1:0] lsu_wstrb_i;
	logic ifu_arready_o, ifu_rlast_o, ifu_rvalid_o;
	logic [DATA_W-1:0] ifu_rdata_o, lsu_rdata_o;
	logic [1:0] ifu_rresp_o, lsu_rresp_o, lsu_bresp_o;
	logic lsu_arready_o, lsu_rvalid_o, lsu_awready_o, lsu_wready_o, lsu_bvalid_o;

	logic [DATA_W-1:0] shadow [SRAM_WORDS]; // expected SRAM contents
	int seed = 85070;
	int errors = 0;
	int unsigned cycle = 0;
	int unsigned lsu_done_cycle, ifu_ar_cycle;

	mem_subsys_top mem_subsys_top_inst (.*);

	always #50 clock = ~clock;
	always @(posedge clock) cycle <= cycle + 1;

	function automatic int word_index(input logic [ADDR_W-1:0] addr);
		return int'(addr[11:2]); // aliases every 4 KB
	endfunction

	function automatic logic [DATA_W-1:0] merge_strobed(input logic [DATA_W-1:0] old_word,
			input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] result;
		result = old_word;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i]) result[8*i +: 8] = new_word[8*i +: 8];
		end
		return result;
	endfunction

	task automatic expect_equal(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] got);
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s expected %h got %h", name, exp, got);
		end
	endtask

	// the b beat completes once bready is high, which the caller may delay
	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, output logic [1:0] resp);
		@(posedge clock);
		lsu_awaddr_i <= addr;
		lsu_wdata_i <= data;
		lsu_wstrb_i <= strb;
		lsu_awvalid_i <= 1'b1;
		lsu_wvalid_i <= 1'b1;
		@(negedge clock);
		while (!lsu_awready_o) @(negedge clock);
		expect_equal("lsu_wready_o", 32'(1'b1), 32'(lsu_wready_o)); // taken with aw
		@(posedge clock);
		lsu_awvalid_i <= 1'b0;
		lsu_wvalid_i <= 1'b0;
		@(negedge clock);
		while (!(lsu_bvalid_o && lsu_bready_i)) @(negedge clock);
		resp = lsu_bresp_o;
		@(posedge clock);
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		lsu_araddr_i <= addr;
		lsu_arvalid_i <= 1'b1;
		@(negedge clock);
		while (!lsu_arready_o) @(negedge clock);
		@(posedge clock);
		lsu_arvalid_i <= 1'b0;
		@(negedge clock);
		while (!(lsu_rvalid_o && lsu_rready_i)) @(negedge clock);
		data = lsu_rdata_o;
		resp = lsu_rresp_o;
		@(posedge clock);
		lsu_done_cycle = cycle; // edge of the r handshake
	endtask

	task automatic sram_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb);
		logic [1:0] resp;
		write_word(addr, data, strb, resp);
		expect_equal("lsu_bresp_o", 32'(RESP_OKAY), 32'(resp));
		shadow[word_index(addr)] = merge_strobed(shadow[word_index(addr)], data, strb);
	endtask

	task automatic sram_check(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
		read_word(addr, data, resp);
		expect_equal("lsu_rresp_o", 32'(RESP_OKAY), 32'(resp));
		expect_equal("lsu_rdata_o", shadow[word_index(addr)], data);
	endtask

	// stall > 0 drops rready for that many cycles before the second beat
	task automatic fetch_burst(input logic [ADDR_W-1:0] addr, input int len, input burst_e burst,
			input int stall);
		int idx;
		@(posedge clock);
		ifu_araddr_i <= addr;
		ifu_arlen_i <= LEN_W'(len);
		ifu_arburst_i <= burst;
		ifu_arvalid_i <= 1'b1;
		@(negedge clock);
		while (!ifu_arready_o) @(negedge clock);
		@(posedge clock);
		ifu_arvalid_i <= 1'b0;
		ifu_ar_cycle = cycle;
		for (int beat = 0; beat <= len; beat++) begin
			if (stall > 0 && beat == 1) begin
				ifu_rready_i <= 1'b0;
				repeat (stall) @(posedge clock);
				ifu_rready_i <= 1'b1;
			end
			@(negedge clock);
			while (!ifu_rvalid_o) @(negedge clock);
			idx = (burst == BURST_INCR) ? (word_index(addr) + beat) % SRAM_WORDS : word_index(addr);
			expect_equal("ifu_rdata_o", shadow[idx], ifu_rdata_o);
			expect_equal("ifu_rresp_o", 32'(RESP_OKAY), 32'(ifu_rresp_o));
			expect_equal("ifu_rlast_o", 32'(beat == len), 32'(ifu_rlast_o));
			@(posedge clock);
		end
	endtask

	initial begin
		logic [DATA_W-1:0] data, v, lo1, lo2;
		logic [ADDR_W-1:0] addr;
		logic [1:0] resp;
		int assert_errors;
		reset = 1'b1;
		ifu_araddr_i = '0;
		ifu_arlen_i = '0;
		ifu_arburst_i = '0;
		ifu_arvalid_i = 1'b0;
		ifu_rready_i = 1'b1;
		lsu_araddr_i = '0;
		lsu_arvalid_i = 1'b0;
		lsu_rready_i = 1'b1;
		lsu_awaddr_i = '0;
		lsu_awvalid_i = 1'b0;
		lsu_wdata_i = '0;
		lsu_wstrb_i = '0;
		lsu_wvalid_i = 1'b0;
		lsu_bready_i = 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		// full word first, then a strobed overwrite
		repeat (4) begin
			addr = 32'h8000_0000 | ($random(seed) & 32'h0000_0FFC);
			sram_store(addr, $random(seed), 4'hF);
			sram_store(addr, $random(seed), 4'($random(seed)));
			sram_check(addr);
		end

		for (int i = 0; i < 4; i++) begin
			sram_store(32'h8000_0100 + 32'(4 * i), $random(seed), 4'hF);
		end
		fetch_burst(32'h8000_0100, 3, BURST_INCR, 0);
		fetch_burst(32'h8000_0108, 1, BURST_FIXED, 0);

		// both request on the same edge, lsu goes first
		fork
			sram_check(32'h8000_0104);
			fetch_burst(32'h8000_0100, 3, BURST_INCR, 0);
		join
		assert (lsu_done_cycle < ifu_ar_cycle) else begin
			errors++;
			$display("LSU read did not complete before the IFU address was accepted");
		end

		v = $random(seed) & 32'h00FF_FFFF; // far from wrapping
		write_word(CLINT_BASE + MTIME_LO_OFS, v, 4'hF, resp);
		expect_equal("lsu_bresp_o", 32'(RESP_OKAY), 32'(resp));
		read_word(CLINT_BASE + MTIME_LO_OFS, lo1, resp);
		expect_equal("lsu_rresp_o", 32'(RESP_OKAY), 32'(resp));
		read_word(CLINT_BASE + MTIME_LO_OFS, lo2, resp);
		assert (lo1 > v && lo2 > lo1) else begin
			errors++;
			$display("FAILED lsu_rdata_o mtime from %h read back %h then %h", v, lo1, lo2);
		end
		read_word(CLINT_BASE | 32'h8, data, resp);
		expect_equal("lsu_rresp_o", 32'(RESP_SLVERR), 32'(resp));

		fetch_burst(32'h8000_0100, 3, BURST_INCR, 5);

		// lsu holds its b and r beats off for a few cycles
		addr = 32'h8000_0300;
		lsu_bready_i <= 1'b0;
		fork
			sram_store(addr + 32'h1000, $random(seed), 4'hF); // same word as addr
			begin
				repeat (6) @(posedge clock);
				lsu_bready_i <= 1'b1;
			end
		join
		lsu_rready_i <= 1'b0;
		fork
			sram_check(addr);
			begin
				repeat (6) @(posedge clock);
				lsu_rready_i <= 1'b1;
			end
		join

		@(posedge clock);
		assert_errors = mem_subsys_top_inst.mem_subsys_checker_inst.assert_errors;
		$display("errors: data checks %0d, assertions %0d", errors, assert_errors);
		if (errors == 0 && assert_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== hw/axi_arbiter.sv ====
// fixed priority lsu write > lsu read > ifu read; grant held until the owner's last beat
module axi_arbiter import bus_pkg::*; (
	input logic clock,
	input logic reset,
	// ifu, read only
	input logic [ADDR_W-1:0] ifu_araddr_i,
	input logic [LEN_W-1:0] ifu_arlen_i,
	input logic [1:0] ifu_arburst_i,
	input logic ifu_arvalid_i,
	output logic ifu_arready_o,
	output logic [DATA_W-1:0] ifu_rdata_o,
	output logic [1:0] ifu_rresp_o,
	output logic ifu_rlast_o,
	output logic ifu_rvalid_o,
	input logic ifu_rready_i,
	// lsu, single beat
	input logic [ADDR_W-1:0] lsu_araddr_i,
	input logic lsu_arvalid_i,
	output logic lsu_arready_o,
	output logic [DATA_W-1:0] lsu_rdata_o,
	output logic [1:0] lsu_rresp_o,
	output logic lsu_rvalid_o,
	input logic lsu_rready_i,
	input logic [ADDR_W-1:0] lsu_awaddr_i,
	input logic lsu_awvalid_i,
	output logic lsu_awready_o,
	input logic [DATA_W-1:0] lsu_wdata_i,
	input logic [STRB_W-1:0] lsu_wstrb_i,
	input logic lsu_wvalid_i,
	output logic lsu_wready_o,
	output logic [1:0] lsu_bresp_o,
	output logic lsu_bvalid_o,
	input logic lsu_bready_i,
	axi_lite_bus_if.master bus
);

	grant_e grant_q, grant_d;
	logic lsu_wr_q, lsu_wr_d; // lsu transaction is a write
	logic data_rd, data_wr, inst_rd;

	assign data_rd = (grant_q == BUSY_DATA) & ~lsu_wr_q;
	assign data_wr = (grant_q == BUSY_DATA) & lsu_wr_q;
	assign inst_rd = (grant_q == BUSY_INST);

	always_comb begin
		grant_d = grant_q;
		lsu_wr_d = lsu_wr_q;
		case (grant_q)
			IDLE: begin
				if (lsu_awvalid_i & lsu_wvalid_i) begin // write needs both channels up
					grant_d = BUSY_DATA;
					lsu_wr_d = 1'b1;
				end else if (lsu_arvalid_i) begin
					grant_d = BUSY_DATA;
					lsu_wr_d = 1'b0;
				end else if (ifu_arvalid_i) begin
					grant_d = BUSY_INST;
				end
			end
			BUSY_DATA: begin
				if (lsu_wr_q ? (bus.bvalid & lsu_bready_i)
						: (bus.rvalid & lsu_rready_i & bus.rlast)) begin
					grant_d = IDLE;
				end
			end
			BUSY_INST: begin
				if (bus.rvalid & ifu_rready_i & bus.rlast) begin
					grant_d = IDLE;
				end
			end
			default: grant_d = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			grant_q <= IDLE;
			lsu_wr_q <= 1'b0;
		end else begin
			grant_q <= grant_d;
			lsu_wr_q <= lsu_wr_d;
		end
	end

	// request mux onto the shared port
	assign bus.araddr = inst_rd ? ifu_araddr_i : lsu_araddr_i;
	assign bus.arlen = inst_rd ? ifu_arlen_i : '0; // lsu is always one beat
	assign bus.arburst = inst_rd ? burst_e'(ifu_arburst_i) : BURST_FIXED;
	assign bus.arvalid = (inst_rd & ifu_arvalid_i) | (data_rd & lsu_arvalid_i);
	assign bus.rready = (inst_rd & ifu_rready_i) | (data_rd & lsu_rready_i);
	assign bus.awaddr = lsu_awaddr_i;
	assign bus.awvalid = data_wr & lsu_awvalid_i;
	assign bus.wdata = lsu_wdata_i;
	assign bus.wstrb = lsu_wstrb_i;
	assign bus.wvalid = data_wr & lsu_wvalid_i;
	assign bus.bready = data_wr & lsu_bready_i;

	// responses back to the owner only
	assign ifu_arready_o = inst_rd & bus.arready;
	assign ifu_rvalid_o = inst_rd & bus.rvalid;
	assign ifu_rlast_o = inst_rd & bus.rlast;
	assign ifu_rdata_o = bus.rdata;
	assign ifu_rresp_o = bus.rresp;
	assign lsu_arready_o = data_rd & bus.arready;
	assign lsu_rvalid_o = data_rd & bus.rvalid;
	assign lsu_rdata_o = bus.rdata;
	assign lsu_rresp_o = bus.rresp;
	assign lsu_awready_o = data_wr & bus.awready;
	assign lsu_wready_o = data_wr & bus.wready;
	assign lsu_bvalid_o = data_wr & bus.bvalid;
	assign lsu_bresp_o = bus.bresp;

endmodule

// ==== hw/axi_lite_bus_if.sv ====
// single-id AXI channel set; the master keeps valid and payload stable until ready
interface axi_lite_bus_if import bus_pkg::*; ();

	// read address
	logic [ADDR_W-1:0] araddr;
	logic [LEN_W-1:0] arlen;
	burst_e arburst;
	logic arvalid;
	logic arready;

	// read data
	logic [DATA_W-1:0] rdata;
	resp_e rresp;
	logic rlast;
	logic rvalid;
	logic rready;

	// write address and data, single beat only
	logic [ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;

	// write response
	resp_e bresp;
	logic bvalid;
	logic bready;

	modport master (
		output araddr, arlen, arburst, arvalid, rready,
		output awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input arready, rdata, rresp, rlast, rvalid,
		input awready, wready, bresp, bvalid
	);

	modport slave (
		input araddr, arlen, arburst, arvalid, rready,
		input awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output arready, rdata, rresp, rlast, rvalid,
		output awready, wready, bresp, bvalid
	);

endinterface

// ==== hw/axi_xbar.sv ====
// timer window goes to the clint, everything else to the SRAM; no decode error path
module axi_xbar import bus_pkg::*; (
	input logic clock,
	input logic reset,
	axi_lite_bus_if.slave up,
	axi_lite_bus_if.master clint,
	axi_lite_bus_if.master sram
);

	logic busy_q; // address accepted, waiting for last beat
	logic sel_q; // 1 = clint
	logic sel_live, sel;
	logic addr_fire, last_fire;

	// only one of the read or write address channels is active at a time
	assign sel_live = addr_in_clint(up.arvalid ? up.araddr : up.awaddr);
	assign sel = busy_q ? sel_q : sel_live;

	assign addr_fire = (up.arvalid & up.arready) | (up.awvalid & up.awready);
	assign last_fire = (up.rvalid & up.rready & up.rlast) | (up.bvalid & up.bready);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q <= 1'b0;
			sel_q <= 1'b0;
		end else if (addr_fire) begin
			busy_q <= 1'b1;
			sel_q <= sel_live;
		end else if (last_fire) begin
			busy_q <= 1'b0;
		end
	end

	// payload to both, valids and readies to the chosen slave
	assign clint.araddr = up.araddr;
	assign clint.arlen = up.arlen;
	assign clint.arburst = up.arburst;
	assign clint.awaddr = up.awaddr;
	assign clint.wdata = up.wdata;
	assign clint.wstrb = up.wstrb;
	assign clint.arvalid = up.arvalid & sel;
	assign clint.rready = up.rready & sel;
	assign clint.awvalid = up.awvalid & sel;
	assign clint.wvalid = up.wvalid & sel;
	assign clint.bready = up.bready & sel;

	assign sram.araddr = up.araddr;
	assign sram.arlen = up.arlen;
	assign sram.arburst = up.arburst;
	assign sram.awaddr = up.awaddr;
	assign sram.wdata = up.wdata;
	assign sram.wstrb = up.wstrb;
	assign sram.arvalid = up.arvalid & ~sel;
	assign sram.rready = up.rready & ~sel;
	assign sram.awvalid = up.awvalid & ~sel;
	assign sram.wvalid = up.wvalid & ~sel;
	assign sram.bready = up.bready & ~sel;

	assign up.arready = sel ? clint.arready : sram.arready;
	assign up.rdata = sel ? clint.rdata : sram.rdata;
	assign up.rresp = sel ? clint.rresp : sram.rresp;
	assign up.rlast = sel ? clint.rlast : sram.rlast;
	assign up.rvalid = sel ? clint.rvalid : sram.rvalid;
	assign up.awready = sel ? clint.awready : sram.awready;
	assign up.wready = sel ? clint.wready : sram.wready;
	assign up.bresp = sel ? clint.bresp : sram.bresp;
	assign up.bvalid = sel ? clint.bvalid : sram.bvalid;

endmodule

// ==== hw/bus_pkg.sv ====
// one outstanding transaction at a time, no AXI IDs, no write bursts; SRAM addresses wrap at 4 KB
package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int LEN_W = 8; // beats minus one

	// word SRAM, indexed by address bits 11:2
	localparam int SRAM_WORDS = 1024;
	localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

	// core-local timer window
	localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
	localparam logic [ADDR_W-1:0] CLINT_MASK = 32'hFFFF_0000;
	localparam logic [ADDR_W-1:0] MTIME_LO_OFS = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] MTIME_HI_OFS = 32'h0000_0004;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'd0,
		RESP_SLVERR = 2'd2 // unmapped timer offset
	} resp_e;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'd0,
		BURST_INCR = 2'd1
	} burst_e;

	// owner of the shared port
	typedef enum logic [1:0] {
		IDLE,
		BUSY_DATA, // lsu read or write
		BUSY_INST // ifu read
	} grant_e;

	function automatic logic addr_in_clint(input logic [ADDR_W-1:0] addr);
		return (addr & CLINT_MASK) == CLINT_BASE;
	endfunction

endpackage

// ==== hw/clint_timer.sv ====
// mtime only, no mtimecmp or interrupt; single beats, wstrb ignored, other offsets give SLVERR
module clint_timer import bus_pkg::*; (
	input logic clock,
	input logic reset,
	axi_lite_bus_if.slave bus
);

	typedef enum logic [1:0] {
		CT_IDLE,
		CT_READ,
		CT_WRESP
	} clint_state_e;

	clint_state_e state_q;
	logic [63:0] mtime_q, mtime_inc;
	logic [ADDR_W-1:0] rd_ofs, wr_ofs;
	logic [DATA_W-1:0] rdata_q;
	resp_e resp_q; // shared by r and b, one transaction at a time
	logic ar_fire, wr_fire;

	assign bus.arready = (state_q == CT_IDLE);
	assign bus.awready = (state_q == CT_IDLE) & ~bus.arvalid & bus.awvalid & bus.wvalid;
	assign bus.wready = bus.awready;
	assign ar_fire = bus.arvalid & bus.arready;
	assign wr_fire = bus.awvalid & bus.awready;
	assign rd_ofs = bus.araddr & ~CLINT_MASK;
	assign wr_ofs = bus.awaddr & ~CLINT_MASK;
	assign mtime_inc = mtime_q + 64'd1;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= CT_IDLE;
			mtime_q <= '0;
		end else begin
			case (state_q)
				CT_IDLE: begin
					if (ar_fire) state_q <= CT_READ;
					else if (wr_fire) state_q <= CT_WRESP;
				end
				CT_READ: if (bus.rready) state_q <= CT_IDLE;
				CT_WRESP: if (bus.bready) state_q <= CT_IDLE;
				default: state_q <= CT_IDLE;
			endcase
			// written word replaces its half, the other half keeps counting
			if (wr_fire && wr_ofs == MTIME_LO_OFS) mtime_q <= {mtime_inc[63:32], bus.wdata};
			else if (wr_fire && wr_ofs == MTIME_HI_OFS) mtime_q <= {bus.wdata, mtime_inc[31:0]};
			else mtime_q <= mtime_inc;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			if (rd_ofs == MTIME_LO_OFS) rdata_q <= mtime_q[31:0];
			else if (rd_ofs == MTIME_HI_OFS) rdata_q <= mtime_q[63:32];
			else rdata_q <= '0;
			resp_q <= (rd_ofs == MTIME_LO_OFS || rd_ofs == MTIME_HI_OFS) ? RESP_OKAY : RESP_SLVERR;
		end else if (wr_fire) begin
			resp_q <= (wr_ofs == MTIME_LO_OFS || wr_ofs == MTIME_HI_OFS) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign bus.rvalid = (state_q == CT_READ);
	assign bus.rlast = bus.rvalid; // always a single beat
	assign bus.rdata = rdata_q;
	assign bus.rresp = resp_q;
	assign bus.bvalid = (state_q == CT_WRESP);
	assign bus.bresp = resp_q;

endmodule

// ==== hw/mem_subsys_top.sv ====
// ifu and lsu share one port; each master must wait for its response before the next request
module mem_subsys_top import bus_pkg::*; (
	input logic clock,
	input logic reset,
	// ifu
	input logic [ADDR_W-1:0] ifu_araddr_i,
	input logic [LEN_W-1:0] ifu_arlen_i,
	input logic [1:0] ifu_arburst_i,
	input logic ifu_arvalid_i,
	output logic ifu_arready_o,
	output logic [DATA_W-1:0] ifu_rdata_o,
	output logic [1:0] ifu_rresp_o,
	output logic ifu_rlast_o,
	output logic ifu_rvalid_o,
	input logic ifu_rready_i,
	// lsu
	input logic [ADDR_W-1:0] lsu_araddr_i,
	input logic lsu_arvalid_i,
	output logic lsu_arready_o,
	output logic [DATA_W-1:0] lsu_rdata_o,
	output logic [1:0] lsu_rresp_o,
	output logic lsu_rvalid_o,
	input logic lsu_rready_i,
	input logic [ADDR_W-1:0] lsu_awaddr_i,
	input logic lsu_awvalid_i,
	output logic lsu_awready_o,
	input logic [DATA_W-1:0] lsu_wdata_i,
	input logic [STRB_W-1:0] lsu_wstrb_i,
	input logic lsu_wvalid_i,
	output logic lsu_wready_o,
	output logic [1:0] lsu_bresp_o,
	output logic lsu_bvalid_o,
	input logic lsu_bready_i
);

	axi_lite_bus_if shared_bus ();
	axi_lite_bus_if clint_bus ();
	axi_lite_bus_if sram_bus ();

	// master ports connect by name
	axi_arbiter axi_arbiter_inst (.*, .bus(shared_bus));

	axi_xbar axi_xbar_inst (
		.clock(clock),
		.reset(reset),
		.up(shared_bus),
		.clint(clint_bus),
		.sram(sram_bus)
	);

	clint_timer clint_timer_inst (.clock(clock), .reset(reset), .bus(clint_bus));

	sram_slave sram_slave_inst (.clock(clock), .reset(reset), .bus(sram_bus));

endmodule

// ==== hw/sram_slave.sv ====
// 4 KB word array, addresses alias every 4 KB; always OKAY, unknown burst codes act as FIXED
module sram_slave import bus_pkg::*; (
	input logic clock,
	input logic reset,
	axi_lite_bus_if.slave bus
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRESP
	} sram_state_e;

	sram_state_e state_q;
	logic [DATA_W-1:0] mem [SRAM_WORDS];
	logic [SRAM_IDX_W-1:0] rd_idx_q, rd_idx_next, wr_idx;
	logic [LEN_W-1:0] beats_q; // beats left after the current one
	burst_e burst_q;
	logic [DATA_W-1:0] rdata_q;
	logic ar_fire, wr_fire, beat_fire, last_beat;

	assign bus.arready = (state_q == ST_IDLE);
	// aw and w are taken together, reads win in the unlikely case of both
	assign bus.awready = (state_q == ST_IDLE) & ~bus.arvalid & bus.awvalid & bus.wvalid;
	assign bus.wready = bus.awready;

	assign ar_fire = bus.arvalid & bus.arready;
	assign wr_fire = bus.awvalid & bus.awready;
	assign beat_fire = bus.rvalid & bus.rready;
	assign last_beat = (beats_q == '0);
	assign wr_idx = bus.awaddr[SRAM_IDX_W+1:2];

	always_comb begin
		if (ar_fire) begin
			rd_idx_next = bus.araddr[SRAM_IDX_W+1:2];
		end else if (burst_q == BURST_INCR) begin
			rd_idx_next = rd_idx_q + SRAM_IDX_W'(1);
		end else begin
			rd_idx_next = rd_idx_q; // fixed burst rereads the same word
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (ar_fire) state_q <= ST_READ;
					else if (wr_fire) state_q <= ST_WRESP;
				end
				ST_READ: if (beat_fire & last_beat) state_q <= ST_IDLE;
				ST_WRESP: if (bus.bvalid & bus.bready) state_q <= ST_IDLE;
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// burst counter and read pipeline
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			beats_q <= bus.arlen;
			burst_q <= bus.arburst;
		end else if (beat_fire) begin
			beats_q <= beats_q - LEN_W'(1);
		end
		if (ar_fire | (beat_fire & ~last_beat)) begin
			rd_idx_q <= rd_idx_next;
			rdata_q <= mem[rd_idx_next]; // next beat ready one cycle later
		end
	end

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (bus.wstrb[i]) mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
			end
		end
	end

	assign bus.rvalid = (state_q == ST_READ);
	assign bus.rlast = bus.rvalid & last_beat;
	assign bus.rdata = rdata_q;
	assign bus.rresp = RESP_OKAY;
	assign bus.bvalid = (state_q == ST_WRESP);
	assign bus.bresp = RESP_OKAY;

endmodule

// ==== project.f ====
hw/bus_pkg.sv
hw/axi_lite_bus_if.sv
hw/axi_arbiter.sv
hw/axi_xbar.sv
hw/sram_slave.sv
hw/clint_timer.sv
hw/mem_subsys_top.sv
bench/mem_subsys_checker.sv
bench/mem_subsys_tb.sv
